//--- source/demux_cfg_pkg.sv
`default_nettype none

// sizing of the read demultiplexer and its ID tracking table
package demux_cfg_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------

  // number of downstream target ports
  localparam int unsigned NUM_TARGETS = 3;
  // width of a target index
  localparam int unsigned SEL_W = 2;
  // low ID bits that get their own in-flight counter
  localparam int unsigned LOOK_BITS = 2;
  // one counter per ID slice
  localparam int unsigned NUM_CNT = 2 ** LOOK_BITS;
  // counter width, a counter is full at all ones
  localparam int unsigned CNT_W = 2;

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------

  // index of a downstream target
  typedef logic [SEL_W-1:0] sel_t;
  // tracked low slice of a transaction ID
  typedef logic [LOOK_BITS-1:0] look_id_t;
  // number of bursts in flight for one ID slice
  typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- source/axi_rd_pkg.sv
`default_nettype none

// field and channel types of the AXI read path
package axi_rd_pkg;

  // ----------------------------------------------------------
  // field widths
  // ----------------------------------------------------------

  localparam int unsigned ID_W = 4;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  // burst length field, beats minus one
  localparam int unsigned LEN_W = 4;

  // ----------------------------------------------------------
  // field types
  // ----------------------------------------------------------

  typedef logic [ID_W-1:0] id_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0] len_t;

  // ----------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------

  // read address request, 24 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  // read data beat, 37 bits
  // last marks the final beat of a burst
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_chan_t;

endpackage

`default_nettype wire

//--- source/rd_id_tracker.sv
`timescale 1ns/100ps
`default_nettype none

// in-flight bookkeeping per low ID slice
// each slice remembers the target it was last sent to
module rd_id_tracker
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  // request being looked up and, on handshake, pushed
  input  wire ar_chan_t ar_i,
  input  wire sel_t     ar_sel_i,
  input  wire logic     ar_push_i,
  // upstream R beat, pops when it fires with last
  input  wire r_chan_t  r_i,
  input  wire logic     r_fire_i,
  // lookup result for ar_i
  output sel_t          lookup_sel_o,
  output logic          lookup_occupied_o,
  output logic          tbl_full_o
);

  // slice of the incoming request and of the returning beat
  look_id_t lookup_id;
  look_id_t pop_id;
  logic     pop_last;

  // one-hot push and pop per counter
  logic [NUM_CNT-1:0] push_en;
  logic [NUM_CNT-1:0] pop_en;
  logic [NUM_CNT-1:0] occupied;
  logic [NUM_CNT-1:0] cnt_full;

  cnt_t [NUM_CNT-1:0] cnt_q;
  sel_t [NUM_CNT-1:0] sel_q;

  assign lookup_id = ar_i.id[LOOK_BITS-1:0];
  assign pop_id    = r_i.id[LOOK_BITS-1:0];
  // a burst ends with its last beat
  assign pop_last  = r_fire_i & r_i.last;

  always_comb begin
    push_en = '0;
    pop_en  = '0;
    push_en[lookup_id] = ar_push_i;
    pop_en[pop_id]     = pop_last;
  end

  // ----------------------------------------------------------
  // counters
  // ----------------------------------------------------------

  // push and pop on the same slice leave the count as it is
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        case ({push_en[i], pop_en[i]})
          2'b10:   cnt_q[i] <= cnt_q[i] + cnt_t'(1);
          2'b01:   cnt_q[i] <= cnt_q[i] - cnt_t'(1);
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  // target of the most recent push per slice
  // only meaningful while the slice is occupied
  always_ff @(posedge clk_i) begin
    if (ar_push_i) begin
      sel_q[lookup_id] <= ar_sel_i;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CNT; i++) begin
      occupied[i] = |cnt_q[i];
      // saturated counter, no further push allowed
      cnt_full[i] = &cnt_q[i];
    end
  end

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------

  assign lookup_sel_o      = sel_q[lookup_id];
  assign lookup_occupied_o = occupied[lookup_id];
  // any full counter stalls every request
  assign tbl_full_o        = |cnt_full;

  // the arbiter never ends a burst that was not pushed here
  a_no_underflow : assert property (@(posedge clk_i) disable iff (reset_i)
    (pop_en & ~occupied) == '0)
    else $error("pop on empty ID slice %0h", pop_id);

endmodule

`default_nettype wire

//--- source/ar_route_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// AR admission and steering
// a request goes out only when its ID slice is free or already
// bound to the same target, and the tracking table has room
module ar_route_ctrl
  import demux_cfg_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  // upstream request control
  input  wire logic                   slv_ar_valid_i,
  input  wire sel_t                   slv_ar_sel_i,
  // per target ready
  input  wire logic [NUM_TARGETS-1:0] tgt_ar_ready_i,
  // tracker lookup for the pending request
  input  wire sel_t                   lookup_sel_i,
  input  wire logic                   lookup_occupied_i,
  input  wire logic                   tbl_full_i,
  output logic      [NUM_TARGETS-1:0] tgt_ar_valid_o,
  output logic                        slv_ar_ready_o,
  output logic                        ar_push_o
);

  logic admit;
  logic ar_valid;
  logic sel_ready;
  logic ar_fire;
  // valid was raised earlier and not yet accepted
  logic lock_d;
  logic lock_q;

  // ----------------------------------------------------------
  // admission
  // ----------------------------------------------------------

  // same-target requests may overtake the occupancy rule
  assign admit = !tbl_full_i &&
                 (!lookup_occupied_i || (lookup_sel_i == slv_ar_sel_i));

  // once raised, valid stays up through the lock
  assign ar_valid  = lock_q | (slv_ar_valid_i & admit);
  assign sel_ready = tgt_ar_ready_i[slv_ar_sel_i];
  assign ar_fire   = ar_valid & sel_ready;

  // upstream sees the selected target's ready
  assign slv_ar_ready_o = ar_fire;
  // tracker counts the burst on the handshake
  assign ar_push_o      = ar_fire;

  // ----------------------------------------------------------
  // valid lock
  // ----------------------------------------------------------

  // set while valid waits for ready, cleared by the handshake
  assign lock_d = ar_valid & ~sel_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ----------------------------------------------------------
  // steering
  // ----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      tgt_ar_valid_o[i] = ar_valid && (slv_ar_sel_i == sel_t'(i));
    end
  end

  // a pending target valid survives any change in the tracker state
  a_ar_valid_held : assert property (@(posedge clk_i) disable iff (reset_i)
    ((tgt_ar_valid_o & ~tgt_ar_ready_i) != '0) |=> (tgt_ar_valid_o == $past(tgt_ar_valid_o)))
    else $error("target AR valid dropped without ready");

endmodule

`default_nettype wire

//--- source/r_resp_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// merge of the target R channels into the upstream R channel
// round-robin, the grant is held until the beat is taken
module r_resp_arbiter
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  wire logic                              clk_i,
  input  wire logic                              reset_i,
  // target side
  input  wire r_chan_t    [NUM_TARGETS-1:0]      tgt_r_i,
  input  wire logic       [NUM_TARGETS-1:0]      tgt_r_valid_i,
  output logic            [NUM_TARGETS-1:0]      tgt_r_ready_o,
  // upstream side
  output r_chan_t                                slv_r_o,
  output logic                                   slv_r_valid_o,
  input  wire logic                              slv_r_ready_i,
  // upstream handshake, feeds the ID tracker
  output logic                                   r_fire_o
);

  // round-robin pointer, highest priority target
  sel_t rr_q;
  // grant kept while a beat is stalled
  sel_t gnt_q;
  logic lock_q;

  sel_t pick;
  sel_t gnt;
  sel_t gnt_next;
  logic found;

  // ----------------------------------------------------------
  // arbitration
  // ----------------------------------------------------------

  // first valid target at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = rr_q;
    for (int k = 0; k < NUM_TARGETS; k++) begin
      idx = int'(rr_q) + k;
      if (idx >= NUM_TARGETS) begin
        idx = idx - NUM_TARGETS;
      end
      if (!found && tgt_r_valid_i[idx]) begin
        pick  = sel_t'(idx);
        found = 1'b1;
      end
    end
  end

  // a stalled beat keeps its grant
  assign gnt = lock_q ? gnt_q : pick;

  // pointer moves just past the served target
  assign gnt_next = (gnt == sel_t'(NUM_TARGETS - 1)) ? '0 : gnt + sel_t'(1);

  // ----------------------------------------------------------
  // forwarding
  // ----------------------------------------------------------

  // no valid target leaves pick on an idle one, so valid is low
  assign slv_r_valid_o = tgt_r_valid_i[gnt];
  assign slv_r_o       = tgt_r_i[gnt];
  assign r_fire_o      = slv_r_valid_o & slv_r_ready_i;

  // upstream ready only reaches the granted target
  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      tgt_r_ready_o[i] = slv_r_ready_i && (gnt == sel_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= slv_r_valid_o & ~slv_r_ready_i;
      gnt_q  <= gnt;
      if (r_fire_o) begin
        rr_q <= gnt_next;
      end
    end
  end

  // stalled beat stays on the bus until accepted
  a_r_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_r_valid_o && !slv_r_ready_i) |=> (slv_r_valid_o && $stable(slv_r_o)))
    else $error("upstream R beat changed while stalled");

endmodule

`default_nettype wire

//--- source/rd_demux_top.sv
`timescale 1ns/100ps
`default_nettype none

// read-only AXI demultiplexer, one upstream port to NUM_TARGETS targets
module rd_demux_top
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  // upstream AR
  input  wire ar_chan_t                     slv_ar_i,
  input  wire sel_t                         slv_ar_sel_i,
  input  wire logic                         slv_ar_valid_i,
  output logic                              slv_ar_ready_o,
  // upstream R
  output r_chan_t                           slv_r_o,
  output logic                              slv_r_valid_o,
  input  wire logic                         slv_r_ready_i,
  // target AR, payload shared by all targets
  output ar_chan_t                          tgt_ar_o,
  output logic       [NUM_TARGETS-1:0]      tgt_ar_valid_o,
  input  wire logic  [NUM_TARGETS-1:0]      tgt_ar_ready_i,
  // target R
  input  wire r_chan_t [NUM_TARGETS-1:0]    tgt_r_i,
  input  wire logic  [NUM_TARGETS-1:0]      tgt_r_valid_i,
  output logic       [NUM_TARGETS-1:0]      tgt_r_ready_o
);

  // tracker lookup for the pending request
  sel_t lookup_sel;
  logic lookup_occupied;
  logic tbl_full;
  // AR handshake and upstream R handshake
  logic ar_push;
  logic r_fire;

  // only the selected target sees valid
  assign tgt_ar_o = slv_ar_i;

  ar_route_ctrl i_ar_route_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .slv_ar_valid_i    (slv_ar_valid_i),
    .slv_ar_sel_i      (slv_ar_sel_i),
    .tgt_ar_ready_i    (tgt_ar_ready_i),
    .lookup_sel_i      (lookup_sel),
    .lookup_occupied_i (lookup_occupied),
    .tbl_full_i        (tbl_full),
    .tgt_ar_valid_o    (tgt_ar_valid_o),
    .slv_ar_ready_o    (slv_ar_ready_o),
    .ar_push_o         (ar_push)
  );

  // pops on the upstream beat so ordering is seen where it matters
  rd_id_tracker i_rd_id_tracker (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .ar_i              (slv_ar_i),
    .ar_sel_i          (slv_ar_sel_i),
    .ar_push_i         (ar_push),
    .r_i               (slv_r_o),
    .r_fire_i          (r_fire),
    .lookup_sel_o      (lookup_sel),
    .lookup_occupied_o (lookup_occupied),
    .tbl_full_o        (tbl_full)
  );

  r_resp_arbiter i_r_resp_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .tgt_r_i       (tgt_r_i),
    .tgt_r_valid_i (tgt_r_valid_i),
    .tgt_r_ready_o (tgt_r_ready_o),
    .slv_r_o       (slv_r_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i),
    .r_fire_o      (r_fire)
  );

endmodule

`default_nettype wire

//--- tb/rd_target_model.sv
`timescale 1ns/100ps
`default_nettype none

// behavioural downstream read target
// accepts AR with a random ready and answers each burst in order
module rd_target_model
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  // index of this target, goes into the top data byte
  input  wire sel_t     tgt_idx_i,
  input  wire ar_chan_t ar_i,
  input  wire logic     ar_valid_i,
  output logic          ar_ready_o,
  output r_chan_t       r_o,
  output logic          r_valid_o,
  input  wire logic     r_ready_i
);

  // accepted bursts, oldest first
  ar_chan_t    pend_q[$];
  ar_chan_t    ar_cap;
  int unsigned beat;
  logic        ar_fire;
  logic        r_fire;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    beat       = 0;
    forever begin
      // inputs only move just after the edge, so the handshake is settled here
      @(negedge clk_i);
      ar_fire = ar_valid_i & ar_ready_o;
      r_fire  = r_valid_o & r_ready_i;
      ar_cap  = ar_i;
      @(posedge clk_i);
      #1;
      if (reset_i) begin
        pend_q.delete();
        beat       = 0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
      end else begin
        // step through the head burst
        if (r_fire) begin
          if (beat == pend_q[0].len) begin
            void'(pend_q.pop_front());
            beat = 0;
          end else begin
            beat++;
          end
        end
        if (ar_fire) begin
          pend_q.push_back(ar_cap);
        end
        // a raised beat stays until it is taken
        if (!r_valid_o || r_fire) begin
          r_valid_o = (pend_q.size() != 0) && ($urandom_range(3) != 0);
        end
        if (r_valid_o) begin
          r_o.id   = pend_q[0].id;
          // target index, low address byte, beat number
          r_o.data = {8'(tgt_idx_i), pend_q[0].addr[7:0], 16'(beat)};
          r_o.last = (beat == pend_q[0].len);
        end
        ar_ready_o = ($urandom_range(1) == 0);
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/rd_demux_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rd_demux_tb
  import demux_cfg_pkg::*;
  import axi_rd_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int NUM_RAND   = 60;
  // random requests plus the four of the saturation test
  localparam int NUM_REQ    = NUM_RAND + 4;
  localparam int NUM_ID     = 2 ** ID_W;
  // outstanding bursts at which a slice counter is full
  localparam int SAT_CNT    = (2 ** CNT_W) - 1;

  // burst expected back upstream
  typedef struct packed {
    sel_t     sel;
    ar_chan_t ar;
  } exp_burst_t;

  logic     clk_i;
  logic     reset_i;
  ar_chan_t ar_drv;
  sel_t     sel_drv;
  logic     ar_valid;
  logic     r_ready;
  // forces upstream R ready low
  logic     r_hold;

  wire logic                          ar_ready;
  wire r_chan_t                       r_beat;
  wire logic                          r_valid;
  wire ar_chan_t                      tgt_ar;
  wire logic    [NUM_TARGETS-1:0]     tgt_ar_valid;
  wire logic    [NUM_TARGETS-1:0]     tgt_ar_ready;
  wire r_chan_t [NUM_TARGETS-1:0]     tgt_r;
  wire logic    [NUM_TARGETS-1:0]     tgt_r_valid;
  wire logic    [NUM_TARGETS-1:0]     tgt_r_ready;

  // reference in-flight table
  int         ref_cnt [NUM_CNT];
  sel_t       ref_sel [NUM_CNT];
  look_id_t   ar_slice;
  logic       ref_full;
  logic       busy_other;
  logic       ref_admit;
  logic       ar_hs;
  logic [NUM_TARGETS-1:0] sel_onehot;

  // scoreboard with one queue per full ID
  exp_burst_t exp_q [NUM_ID][$];
  int         beat_no [NUM_ID];
  r_chan_t    r_got_q;
  r_chan_t    r_exp_q;
  logic       r_chk_q;
  logic       r_stray_q;

  logic started = 1'b0;
  int   err_cnt;
  int   err_mark;
  int   tests_run;
  int   tests_failed;

  rd_demux_top uut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_ar_i       (ar_drv),
    .slv_ar_sel_i   (sel_drv),
    .slv_ar_valid_i (ar_valid),
    .slv_ar_ready_o (ar_ready),
    .slv_r_o        (r_beat),
    .slv_r_valid_o  (r_valid),
    .slv_r_ready_i  (r_ready),
    .tgt_ar_o       (tgt_ar),
    .tgt_ar_valid_o (tgt_ar_valid),
    .tgt_ar_ready_i (tgt_ar_ready),
    .tgt_r_i        (tgt_r),
    .tgt_r_valid_i  (tgt_r_valid),
    .tgt_r_ready_o  (tgt_r_ready)
  );

  for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_tgt
    rd_target_model i_tgt (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .tgt_idx_i  (sel_t'(t)),
      .ar_i       (tgt_ar),
      .ar_valid_i (tgt_ar_valid[t]),
      .ar_ready_o (tgt_ar_ready[t]),
      .r_o        (tgt_r[t]),
      .r_valid_o  (tgt_r_valid[t]),
      .r_ready_i  (tgt_r_ready[t])
    );
  end

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // ----------------------------------------------------------
  // reference table and scoreboard
  // ----------------------------------------------------------

  always_comb begin
    ref_full = 1'b0;
    for (int i = 0; i < NUM_CNT; i++) begin
      if (ref_cnt[i] >= SAT_CNT) begin
        ref_full = 1'b1;
      end
    end
  end

  assign ar_slice   = ar_drv.id[LOOK_BITS-1:0];
  // slice still owned by another target
  assign busy_other = (ref_cnt[ar_slice] != 0) && (ref_sel[ar_slice] != sel_drv);
  assign ref_admit  = !ref_full && !busy_other;
  assign ar_hs      = |(tgt_ar_valid & tgt_ar_ready);
  assign sel_onehot = NUM_TARGETS'(1) << sel_drv;

  always @(posedge clk_i) begin
    exp_burst_t cur;
    id_t        rid;
    started   = 1'b1;
    r_chk_q   = 1'b0;
    r_stray_q = 1'b0;
    if (reset_i) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        ref_cnt[i] = 0;
        ref_sel[i] = '0;
      end
    end else begin
      // beat before request since a burst handed out on this edge cannot answer yet
      if (r_valid && r_ready) begin
        rid     = r_beat.id;
        r_chk_q = 1'b1;
        r_got_q = r_beat;
        if (exp_q[rid].size() == 0) begin
          r_stray_q = 1'b1;
        end else begin
          cur          = exp_q[rid][0];
          r_exp_q.id   = cur.ar.id;
          r_exp_q.data = {8'(cur.sel), cur.ar.addr[7:0], 16'(beat_no[rid])};
          r_exp_q.last = (beat_no[rid] == int'(cur.ar.len));
          if (r_exp_q.last) begin
            void'(exp_q[rid].pop_front());
            beat_no[rid] = 0;
            ref_cnt[rid[LOOK_BITS-1:0]]--;
          end else begin
            beat_no[rid]++;
          end
        end
      end
      if (ar_valid && ar_ready) begin
        exp_q[ar_drv.id].push_back(exp_burst_t'({sel_drv, ar_drv}));
        ref_cnt[ar_slice]++;
        ref_sel[ar_slice] = sel_drv;
      end
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------

  // quiet outputs through reset and the cycle after
  a_reset_ar : assert property (@(posedge clk_i)
    (started && (reset_i || $past(reset_i))) |-> (tgt_ar_valid == '0))
    else begin
      err_cnt++;
      $display("MISMATCH tgt_ar_valid_o got %h exp 0", $sampled(tgt_ar_valid));
    end

  a_reset_r : assert property (@(posedge clk_i)
    (started && (reset_i || $past(reset_i))) |-> !r_valid)
    else begin
      err_cnt++;
      $display("MISMATCH slv_r_valid_o got %h exp 0", $sampled(r_valid));
    end

  // handshake lands on the selected target only
  a_route_valid : assert property (@(posedge clk_i) disable iff (reset_i)
    ar_hs |-> (tgt_ar_valid == sel_onehot))
    else begin
      err_cnt++;
      $display("MISMATCH tgt_ar_valid_o got %h exp %h",
               $sampled(tgt_ar_valid), $sampled(sel_onehot));
    end

  a_route_payload : assert property (@(posedge clk_i) disable iff (reset_i)
    ar_hs |-> (tgt_ar == ar_drv))
    else begin
      err_cnt++;
      $display("MISMATCH tgt_ar_o got %h exp %h", $sampled(tgt_ar), $sampled(ar_drv));
    end

  // slice owned elsewhere keeps every target valid low
  a_block : assert property (@(posedge clk_i) disable iff (reset_i)
    (ar_valid && busy_other) |-> (tgt_ar_valid == '0))
    else begin
      err_cnt++;
      $display("MISMATCH tgt_ar_valid_o got %h exp 0 while ID slice is busy elsewhere",
               $sampled(tgt_ar_valid));
    end

  // an admissible request is not held back
  a_same_tgt : assert property (@(posedge clk_i) disable iff (reset_i)
    (ar_valid && ref_admit) |-> (tgt_ar_valid == sel_onehot))
    else begin
      err_cnt++;
      $display("MISMATCH tgt_ar_valid_o got %h exp %h",
               $sampled(tgt_ar_valid), $sampled(sel_onehot));
    end

  a_saturate : assert property (@(posedge clk_i) disable iff (reset_i)
    ref_full |-> !ar_hs)
    else begin
      err_cnt++;
      $display("AR request accepted while an ID counter was saturated");
    end

  a_ar_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    (|(tgt_ar_valid & ~tgt_ar_ready)) |=>
      ((tgt_ar_valid == $past(tgt_ar_valid)) && $stable(tgt_ar)))
    else begin
      err_cnt++;
      $display("target AR valid or payload changed before ready");
    end

  a_r_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_beat)))
    else begin
      err_cnt++;
      $display("upstream R beat changed or dropped before ready");
    end

  a_r_data : assert property (@(posedge clk_i) disable iff (reset_i)
    (r_chk_q && !r_stray_q) |-> (r_got_q == r_exp_q))
    else begin
      err_cnt++;
      $display("MISMATCH slv_r_o got %h exp %h", $sampled(r_got_q), $sampled(r_exp_q));
    end

  a_r_stray : assert property (@(posedge clk_i) disable iff (reset_i) !r_stray_q)
    else begin
      err_cnt++;
      $display("R beat with ID %h arrived with no burst outstanding", $sampled(r_got_q.id));
    end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  // upstream R ready is random unless held low
  initial begin
    logic hold;
    r_ready = 1'b0;
    forever begin
      @(negedge clk_i);
      hold = r_hold;
      @(posedge clk_i);
      #1;
      r_ready = !hold && ($urandom_range(3) != 0);
    end
  end

  // present one request and wait for its handshake
  task automatic issue_ar(input id_t id, input sel_t sel, input len_t len, input addr_t addr);
    logic fired;
    ar_drv.id   = id;
    ar_drv.addr = addr;
    ar_drv.len  = len;
    sel_drv     = sel;
    ar_valid    = 1'b1;
    fired       = 1'b0;
    while (!fired) begin
      @(negedge clk_i);
      fired = ar_ready;
      @(posedge clk_i);
      #1;
    end
    ar_valid = 1'b0;
  endtask

  // wait until every burst has come back
  task automatic drain();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(posedge clk_i);
      #1;
      busy = 0;
      for (int i = 0; i < NUM_ID; i++) begin
        busy += exp_q[i].size();
      end
    end
    repeat (3) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    int delta;
    delta = err_cnt - err_mark;
    tests_run++;
    if (delta != 0) begin
      tests_failed++;
    end
    $display("test %s: %s (%0d errors)", name, (delta == 0) ? "ok" : "FAILED", delta);
    err_mark = err_cnt;
  endtask

  // run limit scales with the request count
  initial begin
    #(NUM_REQ * 200 * CLK_PERIOD);
    $display("timeout: traffic did not finish within %0d cycles", NUM_REQ * 200);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int gap;
    void'($urandom(89));
    reset_i      = 1'b1;
    ar_drv       = '0;
    sel_drv      = '0;
    ar_valid     = 1'b0;
    r_hold       = 1'b0;
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    repeat (2) begin
      @(posedge clk_i);
      #1;
    end
    end_test("reset");

    // random IDs, targets and lengths
    for (int n = 0; n < NUM_RAND; n++) begin
      issue_ar(id_t'($urandom_range(NUM_ID - 1)), sel_t'($urandom_range(NUM_TARGETS - 1)),
               len_t'($urandom_range(3)), addr_t'($urandom));
      gap = $urandom_range(2);
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
    end
    drain();
    end_test("random traffic");

    // three bursts on slice 1 with no R returned fill its counter
    r_hold = 1'b1;
    for (int n = 0; n < 3; n++) begin
      issue_ar(id_t'(4 * n + 1), sel_t'(2), len_t'(n), addr_t'($urandom));
    end
    // fourth request must wait until R flows again
    fork
      issue_ar(id_t'($urandom_range(NUM_ID - 1)), sel_t'($urandom_range(NUM_TARGETS - 1)),
               len_t'(0), addr_t'($urandom));
      begin
        repeat (20) begin
          @(posedge clk_i);
          #1;
        end
        r_hold = 1'b0;
      end
    join
    drain();
    end_test("saturation");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
source/demux_cfg_pkg.sv
source/axi_rd_pkg.sv
source/rd_id_tracker.sv
source/ar_route_ctrl.sv
source/r_resp_arbiter.sv
source/rd_demux_top.sv
tb/rd_target_model.sv
tb/rd_demux_tb.sv
